//--- cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Number of sets, each holding one line per way
`define SETS 16

// 32-bit words per cache line
`define WORDS 4

// Byte address width on both buses
`define ADDR_BITS 16

// Address bits left over after set index and the 4-bit line offset
`define TAG_BITS (`ADDR_BITS - $clog2(`SETS) - 4)

`endif

//--- busPkg.sv
`default_nettype none

`include "cache_consts.svh"

package busPkg;

  // One processor access, held by the input side while it is in flight
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`ADDR_BITS-1:0]  addr;
    logic [31:0]            wdata;
    logic [3:0]             sel;
  } cpuReq;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } cpuResp;

  // Line transfer command towards memory
  typedef struct packed {
    logic                   start;
    logic                   write;
    logic [`ADDR_BITS-5:0]  lineAddr;
    logic [31:0]            wdata;
  } lineReq;

  // Per-word progress of a line transfer
  typedef struct packed {
    logic                        wordDone;
    logic [$clog2(`WORDS)-1:0]   wordIdx;
    logic [31:0]                 rdata;
    logic                        lineDone;
  } lineResp;

endpackage

`default_nettype wire

//--- cacheLinePkg.sv
`default_nettype none

`include "cache_consts.svh"

package cacheLinePkg;

  typedef logic [$clog2(`SETS)-1:0]  setIdx;
  typedef logic [$clog2(`WORDS)-1:0] wordSel;

  // Byte address split, tag in the upper bits
  typedef struct packed {
    logic [`TAG_BITS-1:0] tag;
    setIdx                index;
    wordSel               word;
    logic [1:0]           byteOff;
  } addrFields;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`TAG_BITS-1:0] tag;
  } tagEntry;

  // Store command, reads follow set and word combinationally
  typedef struct packed {
    setIdx       set;
    wordSel      word;
    logic        way;
    logic [3:0]  mask;
    logic [31:0] wdata;
    logic        dataWe;
    logic        tagWe;
    tagEntry     newTag;
    logic        lruWe;
    logic        lruVal;
  } storeCtl;

  typedef enum logic [2:0] {
    idle,
    lookup,
    writeBack,
    refill,
    respond,
    flushScan
  } ctrlState;

endpackage

`default_nettype wire

//--- cpuPort.sv
`default_nettype none

`include "cache_consts.svh"

module cpuPort
  import busPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`ADDR_BITS-1:0] adr,
  input  logic [31:0]           dat,
  input  logic [3:0]            sel,
  output logic                  ack,
  output logic [31:0]           readData,
  output cpuReq                 req,
  input  cpuResp                resp
);

  logic                  busy;
  logic                  reqValid;
  logic                  capture;
  logic                  weQ;
  logic [`ADDR_BITS-1:0] adrQ;
  logic [31:0]           datQ;
  logic [3:0]            selQ;

  // Master still holds stb during the ack cycle, so skip it there
  assign capture = cyc & stb & ~busy & ~ack;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      busy     <= 1'b0;
      reqValid <= 1'b0;
      ack      <= 1'b0;
    end else begin
      reqValid <= capture;
      ack      <= resp.done;
      if (capture) begin
        busy <= 1'b1;
      end else if (resp.done) begin
        busy <= 1'b0;
      end
    end
  end

  // Access fields stay put until the next capture
  always_ff @(posedge clk) begin
    if (capture) begin
      weQ  <= we;
      adrQ <= adr;
      datQ <= dat;
      selQ <= sel;
    end
    if (resp.done) begin
      readData <= resp.rdata;
    end
  end

  assign req = '{valid: reqValid, write: weQ, addr: adrQ, wdata: datQ, sel: selQ};

endmodule

`default_nettype wire

//--- cacheController.sv
`default_nettype none

`include "cache_consts.svh"

module cacheController
  import busPkg::*, cacheLinePkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              flush,
  output logic              busy,
  input  cpuReq             req,
  output cpuResp            resp,
  output storeCtl           ctl,
  input  tagEntry [1:0]     ways,
  input  logic [1:0][31:0]  wayData,
  input  logic              lru,
  output lineReq            line,
  input  lineResp           lineStat
);

  ctrlState               state;
  addrFields              fields;
  logic                   probe;
  logic                   hit0;
  logic                   hit1;
  logic                   hitAny;
  logic                   hitWay;
  logic                   victim;
  logic                   victimDirty;
  logic                   victimWay;
  logic                   kick;
  logic                   flushing;
  logic                   flushPend;
  logic [$clog2(`SETS):0] flushCnt;
  setIdx                  flushSet;
  logic                   flushWay;
  setIdx                  curSet;
  logic [31:0]            rdataQ;

  // Request fields are held by the input side for the whole access
  assign fields = addrFields'(req.addr);

  // Flush counter walks way first, then set
  assign flushSet = flushCnt[$clog2(`SETS):1];
  assign flushWay = flushCnt[0];
  assign curSet   = flushing ? flushSet : fields.index;

  assign probe  = (state == idle && req.valid) || state == lookup;
  assign hit0   = ways[0].valid && ways[0].tag == fields.tag;
  assign hit1   = ways[1].valid && ways[1].tag == fields.tag;
  assign hitAny = hit0 | hit1;
  assign hitWay = hit1;

  // Free way first, otherwise the least recently used one
  assign victim      = ~ways[0].valid ? 1'b0 : (~ways[1].valid ? 1'b1 : lru);
  assign victimDirty = ways[victim].valid & ways[victim].dirty;

  assign busy = flushPend | flushing;
  assign resp = '{done: state == respond, rdata: rdataQ};

  always_comb begin
    line.start    = kick;
    line.write    = state == writeBack;
    line.wdata    = wayData[victimWay];
    line.lineAddr = {fields.tag, fields.index};
    if (state == writeBack) begin
      line.lineAddr = {ways[victimWay].tag, curSet};
    end
  end

  always_comb begin
    ctl        = '0;
    ctl.set    = curSet;
    ctl.word   = fields.word;
    ctl.way    = hitWay;
    ctl.mask   = req.sel;
    ctl.wdata  = req.wdata;
    ctl.newTag = '{valid: 1'b1, dirty: 1'b1, tag: fields.tag};
    case (state)
      idle, lookup: begin
        if (probe && hitAny) begin
          ctl.dataWe = req.write;
          ctl.tagWe  = req.write;
          ctl.lruWe  = 1'b1;
          ctl.lruVal = ~hitWay;
        end
      end
      writeBack: begin
        // memPort loads the next word on the acknowledge edge
        ctl.way  = victimWay;
        ctl.word = lineStat.wordIdx + wordSel'(lineStat.wordDone);
        if (flushing) begin
          ctl.tagWe  = lineStat.lineDone;
          ctl.newTag = '{valid: 1'b1, dirty: 1'b0, tag: ways[victimWay].tag};
        end
      end
      refill: begin
        ctl.way    = victimWay;
        ctl.word   = lineStat.wordIdx;
        ctl.mask   = 4'hF;
        ctl.wdata  = lineStat.rdata;
        ctl.dataWe = lineStat.wordDone;
        ctl.tagWe  = lineStat.lineDone;
        ctl.newTag = '{valid: 1'b1, dirty: 1'b0, tag: fields.tag};
      end
      flushScan: begin
        ctl.way = flushWay;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= idle;
      kick      <= 1'b0;
      victimWay <= 1'b0;
      flushing  <= 1'b0;
      flushPend <= 1'b0;
      flushCnt  <= '0;
    end else begin
      kick <= 1'b0;
      if (flush) begin
        flushPend <= 1'b1;
      end
      if (probe) begin
        if (hitAny) begin
          state <= respond;
        end else begin
          victimWay <= victim;
          kick      <= 1'b1;
          state     <= victimDirty ? writeBack : refill;
        end
      end else begin
        case (state)
          idle: begin
            if (flushPend) begin
              flushPend <= flush;
              flushing  <= 1'b1;
              flushCnt  <= '0;
              state     <= flushScan;
            end
          end
          respond: state <= idle;
          writeBack: begin
            if (lineStat.lineDone) begin
              // Flush rescans the same entry, which is clean by now
              if (flushing) begin
                state <= flushScan;
              end else begin
                kick  <= 1'b1;
                state <= refill;
              end
            end
          end
          refill: begin
            if (lineStat.lineDone) begin
              state <= lookup;
            end
          end
          flushScan: begin
            if (ways[flushWay].valid && ways[flushWay].dirty) begin
              victimWay <= flushWay;
              kick      <= 1'b1;
              state     <= writeBack;
            end else if (&flushCnt) begin
              flushing <= 1'b0;
              state    <= idle;
            end else begin
              flushCnt <= flushCnt + 1'b1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (probe && hitAny) begin
      rdataQ <= wayData[hitWay];
    end
  end

endmodule

`default_nettype wire

//--- cacheStore.sv
`default_nettype none

`include "cache_consts.svh"

module cacheStore
  import cacheLinePkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  storeCtl           ctl,
  output tagEntry [1:0]     ways,
  output logic [1:0][31:0]  wayData,
  output logic              lru
);

  localparam int LineWords = `SETS * `WORDS;

  logic [1:0][`SETS-1:0]       validQ;
  logic [1:0][`SETS-1:0]       dirtyQ;
  logic [`SETS-1:0]            lruQ;
  logic [`TAG_BITS-1:0]        tagMem  [2][`SETS];
  logic [31:0]                 dataMem [2][LineWords];
  logic [$clog2(LineWords)-1:0] wordAddr;

  assign wordAddr = {ctl.set, ctl.word};

  // Status bits, cleared on reset
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validQ <= '0;
      dirtyQ <= '0;
      lruQ   <= '0;
    end else begin
      if (ctl.tagWe) begin
        validQ[ctl.way][ctl.set] <= ctl.newTag.valid;
        dirtyQ[ctl.way][ctl.set] <= ctl.newTag.dirty;
      end
      if (ctl.lruWe) begin
        lruQ[ctl.set] <= ctl.lruVal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.tagWe) begin
      tagMem[ctl.way][ctl.set] <= ctl.newTag.tag;
    end
    if (ctl.dataWe) begin
      // One byte lane per mask bit
      for (int b = 0; b < 4; b++) begin
        if (ctl.mask[b]) begin
          dataMem[ctl.way][wordAddr][8*b +: 8] <= ctl.wdata[8*b +: 8];
        end
      end
    end
  end

  // Both ways are read at once for the compare
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      ways[w].valid = validQ[w][ctl.set];
      ways[w].dirty = dirtyQ[w][ctl.set];
      ways[w].tag   = tagMem[w][ctl.set];
      wayData[w]    = dataMem[w][wordAddr];
    end
  end

  assign lru = lruQ[ctl.set];

endmodule

`default_nettype wire

//--- memPort.sv
`default_nettype none

`include "cache_consts.svh"

module memPort
  import busPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  lineReq                line,
  output lineResp               stat,
  output logic                  memCyc,
  output logic                  memStb,
  output logic                  memWe,
  output logic [`ADDR_BITS-1:0] memAdr,
  output logic [31:0]           memDatOut,
  input  logic                  memAck,
  input  logic [31:0]           memDatIn
);

  logic                        active;
  logic                        writeQ;
  logic                        begin1;
  logic                        wordDone;
  logic [$clog2(`WORDS)-1:0]   cnt;
  logic [`ADDR_BITS-5:0]       lineQ;
  logic [31:0]                 datQ;

  assign begin1   = line.start & ~active;
  assign wordDone = active & memAck;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      active <= 1'b0;
      writeQ <= 1'b0;
      cnt    <= '0;
    end else if (begin1) begin
      active <= 1'b1;
      writeQ <= line.write;
      cnt    <= '0;
    end else if (wordDone) begin
      // Counter wraps back to zero after the last word
      cnt <= cnt + 1'b1;
      if (&cnt) begin
        active <= 1'b0;
      end
    end
  end

  // Outgoing word is taken when it goes on the bus
  always_ff @(posedge clk) begin
    if (begin1) begin
      lineQ <= line.lineAddr;
      datQ  <= line.wdata;
    end else if (wordDone && !(&cnt)) begin
      datQ <= line.wdata;
    end
  end

  assign memCyc    = active;
  assign memStb    = active;
  assign memWe     = active & writeQ;
  assign memAdr    = {lineQ, cnt, 2'b00};
  assign memDatOut = datQ;

  assign stat = '{wordDone: wordDone, wordIdx: cnt, rdata: memDatIn,
                  lineDone: wordDone & (&cnt)};

endmodule

`default_nettype wire

//--- dataCache.sv
`default_nettype none

`include "cache_consts.svh"

module dataCache
  import busPkg::*, cacheLinePkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  output logic                  busy,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`ADDR_BITS-1:0] adr,
  input  logic [31:0]           dat,
  input  logic [3:0]            sel,
  output logic                  ack,
  output logic [31:0]           readData,
  output logic                  memCyc,
  output logic                  memStb,
  output logic                  memWe,
  output logic [`ADDR_BITS-1:0] memAdr,
  output logic [31:0]           memDatOut,
  input  logic                  memAck,
  input  logic [31:0]           memDatIn
);

  cpuReq             req;
  cpuResp            resp;
  storeCtl           ctl;
  tagEntry [1:0]     ways;
  logic [1:0][31:0]  wayData;
  logic              lru;
  lineReq            line;
  lineResp           lineStat;

  cpuPort cpuPort_i (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat(dat), .sel(sel), .ack(ack), .readData(readData), .req(req), .resp(resp)
  );

  cacheController cacheController_i (
    .clk(clk), .reset(reset), .flush(flush), .busy(busy), .req(req), .resp(resp),
    .ctl(ctl), .ways(ways), .wayData(wayData), .lru(lru), .line(line),
    .lineStat(lineStat)
  );

  cacheStore cacheStore_i (
    .clk(clk), .reset(reset), .ctl(ctl), .ways(ways), .wayData(wayData), .lru(lru)
  );

  memPort memPort_i (
    .clk(clk), .reset(reset), .line(line), .stat(lineStat), .memCyc(memCyc),
    .memStb(memStb), .memWe(memWe), .memAdr(memAdr), .memDatOut(memDatOut),
    .memAck(memAck), .memDatIn(memDatIn)
  );

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock #(
  parameter int Period = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- memModel.sv
`default_nettype none

`include "cache_consts.svh"

module memModel (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`ADDR_BITS-1:0] adr,
  input  logic [31:0]           wrData,
  output logic                  ack,
  output logic [31:0]           rdData
);

  localparam int Depth = 1 << (`ADDR_BITS - 2);

  logic [31:0]           words   [Depth];
  logic [`ADDR_BITS-1:0] logAddr [256];
  logic [31:0]           logData [256];
  logic [31:0]           rnd;
  logic [1:0]            waitCnt;
  int                    writeCount;
  int                    ackCount;
  integer                seed;

  // Each word starts as its word address XOR a fixed pattern
  initial begin
    seed       = 15726;
    writeCount = 0;
    ackCount   = 0;
    for (int i = 0; i < Depth; i++) begin
      words[i] = i ^ 32'hA5A5_0000;
    end
  end

  always @(posedge clk, posedge reset) begin
    if (reset) begin
      ack     <= 1'b0;
      rdData  <= '0;
      waitCnt <= '0;
    end else begin
      ack <= 1'b0;
      // Next word is only looked at once the previous ack has dropped
      if (cyc && stb && !ack) begin
        if (waitCnt != 2'd0) begin
          waitCnt <= waitCnt - 1'b1;
        end else begin
          rnd = $random(seed);
          waitCnt <= rnd[1:0];
          ack     <= 1'b1;
          ackCount++;
          if (we) begin
            words[adr[`ADDR_BITS-1:2]] = wrData;
            logAddr[writeCount[7:0]]   = adr;
            logData[writeCount[7:0]]   = wrData;
            writeCount++;
          end else begin
            rdData <= words[adr[`ADDR_BITS-1:2]];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dataCacheTb.sv
`default_nettype none

`include "cache_consts.svh"

module dataCacheTb;

  localparam int Depth       = 1 << (`ADDR_BITS - 2);
  localparam int Accesses    = 240;
  localparam int MissCycles  = 60;
  localparam int FlushCycles = 2 * `SETS * 30;
  localparam int CycleLimit  = 10 + Accesses * MissCycles + FlushCycles + 1000;
  localparam int ExpectAny   = 0;
  localparam int ExpectHit   = 1;
  localparam int ExpectMiss  = 2;

  logic                  clk;
  logic                  reset;
  logic                  flush;
  logic                  busy;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`ADDR_BITS-1:0] adr;
  logic [31:0]           dat;
  logic [3:0]            sel;
  logic                  ack;
  logic [31:0]           readData;
  logic                  memCyc;
  logic                  memStb;
  logic                  memWe;
  logic [`ADDR_BITS-1:0] memAdr;
  logic [31:0]           memDatOut;
  logic                  memAck;
  logic [31:0]           memDatIn;

  logic [31:0] refMem [Depth];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  integer      seed;

  tbClock clkGen_i (.clk(clk));

  dataCache dut_i (
    .clk(clk), .reset(reset), .flush(flush), .busy(busy), .cyc(cyc), .stb(stb),
    .we(we), .adr(adr), .dat(dat), .sel(sel), .ack(ack), .readData(readData),
    .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memAdr(memAdr),
    .memDatOut(memDatOut), .memAck(memAck), .memDatIn(memDatIn)
  );

  memModel mem_i (
    .clk(clk), .reset(reset), .cyc(memCyc), .stb(memStb), .we(memWe), .adr(memAdr),
    .wrData(memDatOut), .ack(memAck), .rdData(memDatIn)
  );

  // Lanes with their select bit set take the new byte
  function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                             input logic [31:0] upd,
                                             input logic [3:0]  s);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        res[8*b +: 8] = upd[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] got);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, got);
    end
  endtask

  task automatic expectTrue(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, msg);
    end
  endtask

  task automatic checkIdle();
    checkValue("ack", 32'd0, 32'(ack));
    checkValue("busy", 32'd0, 32'(busy));
    checkValue("memCyc", 32'd0, 32'(memCyc));
    checkValue("memStb", 32'd0, 32'(memStb));
  endtask

  // One Wishbone classic access, driven on the falling edge
  task automatic driveAccess(input logic wr, input logic [`ADDR_BITS-1:0] a,
                             input logic [31:0] d, input logic [3:0] s,
                             output logic [31:0] rd, output int lat);
    lat = 0;
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = wr;
    adr = a;
    dat = d;
    sel = s;
    do begin
      @(negedge clk);
      lat++;
    end while (!ack);
    rd  = readData;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic access(input logic wr, input logic [`ADDR_BITS-1:0] a,
                        input logic [31:0] d, input logic [3:0] s, input int mode);
    logic [31:0] rd;
    logic [31:0] expected;
    int          lat;
    int          acksBefore;
    int          writesBefore;
    acksBefore   = mem_i.ackCount;
    writesBefore = mem_i.writeCount;
    expected     = refMem[a[`ADDR_BITS-1:2]];
    driveAccess(wr, a, d, s, rd, lat);
    if (wr) begin
      refMem[a[`ADDR_BITS-1:2]] = mergeBytes(expected, d, s);
    end else begin
      checkValue($sformatf("readData[%h]", a), expected, rd);
    end
    if (mode == ExpectHit) begin
      checkValue("ack latency", 32'd3, lat);
      checkValue("memory acks", acksBefore, mem_i.ackCount);
      checkValue("memory writes", writesBefore, mem_i.writeCount);
    end else if (mode == ExpectMiss) begin
      expectTrue(mem_i.ackCount - acksBefore >= 4,
                 $sformatf("miss at %h made fewer than four memory transfers", a));
    end
  endtask

  initial begin
    logic [31:0]           rnd;
    logic [31:0]           data;
    logic [`ADDR_BITS-1:0] a;
    logic [`ADDR_BITS-1:0] lastAdr;
    logic [`ADDR_BITS-1:0] wa;
    logic [3:0]            s;
    int                    w0;
    int                    idx;
    seed = 15726;
    for (int i = 0; i < Depth; i++) begin
      refMem[i] = i ^ 32'hA5A5_0000;
    end
    reset = 1'b1;
    flush = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat   = '0;
    sel   = '0;

    // Outputs stay quiet through reset and just after
    repeat (10) begin
      @(negedge clk);
      checkIdle();
    end
    reset = 1'b0;
    @(negedge clk);
    checkIdle();

    // Read miss, then the same word as a hit
    access(1'b0, 16'h0014, 32'h0, 4'hF, ExpectMiss);
    access(1'b0, 16'h0014, 32'h0, 4'hF, ExpectHit);

    // Partial write hit stays in the cache
    access(1'b1, 16'h0014, 32'h1234_5678, 4'b0101, ExpectHit);
    access(1'b0, 16'h0014, 32'h0, 4'hF, ExpectHit);

    // Set 5 holds two of the lines 0x10xx, 0x20xx, 0x30xx, 0x40xx
    access(1'b1, 16'h1054, 32'hCAFE_0001, 4'hF, ExpectMiss);
    access(1'b0, 16'h2050, 32'h0, 4'hF, ExpectMiss);
    access(1'b0, 16'h1054, 32'h0, 4'hF, ExpectHit);
    w0 = mem_i.writeCount;
    access(1'b1, 16'h3058, 32'hBEEF_0002, 4'b1100, ExpectMiss);
    checkValue("memory writes", w0, mem_i.writeCount);
    access(1'b0, 16'h1054, 32'h0, 4'hF, ExpectHit);
    w0 = mem_i.writeCount;
    access(1'b0, 16'h4050, 32'h0, 4'hF, ExpectMiss);
    checkValue("memory writes", 32'(w0 + 4), mem_i.writeCount);
    for (int i = 0; i < 4; i++) begin
      idx = w0 + i;
      wa  = 16'h3050 + 16'(4 * i);
      checkValue("write-back address", 32'(wa), 32'(mem_i.logAddr[idx[7:0]]));
      checkValue("write-back data", refMem[wa[`ADDR_BITS-1:2]], mem_i.logData[idx[7:0]]);
    end

    // Random writes, then flush everything dirty
    lastAdr = '0;
    for (int n = 0; n < 20; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      a    = rnd[15:0] & 16'h07FC;
      s    = (rnd[19:16] == 4'h0) ? 4'hF : rnd[19:16];
      access(1'b1, a, data, s, ExpectAny);
      lastAdr = a;
    end
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    expectTrue(busy, "busy did not rise after the flush request");
    while (busy) begin
      @(negedge clk);
    end
    checkValue("memCyc", 32'd0, 32'(memCyc));
    for (int i = 0; i < Depth; i++) begin
      checkValue($sformatf("memory[%h]", i), refMem[i], mem_i.words[i]);
    end
    access(1'b0, lastAdr, 32'h0, 4'hF, ExpectHit);

    // Mixed traffic over a small range
    for (int n = 0; n < 200; n++) begin
      rnd  = $random(seed);
      data = $random(seed);
      a    = rnd[15:0] & 16'h07FC;
      s    = (rnd[19:16] == 4'h0) ? 4'hF : rnd[19:16];
      if (rnd[20]) begin
        access(1'b1, a, data, s, ExpectAny);
      end else begin
        access(1'b0, a, 32'h0, 4'hF, ExpectAny);
      end
    end

    @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
busPkg.sv
cacheLinePkg.sv
cpuPort.sv
cacheController.sv
cacheStore.sv
memPort.sv
dataCache.sv
tbClock.sv
memModel.sv
dataCacheTb.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module dataCacheTb -o simv

out=$(./obj_dir/simv)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
